/* include/capture_consts.svh */
`ifndef CAPTURE_CONSTS_SVH
`define CAPTURE_CONSTS_SVH

// adc sample and packed word widths
`define CAP_SAMPLE_W      12
`define CAP_WORD_W        64

// fifo depths, both must be powers of two
`define CAP_SAMPLE_DEPTH  16
`define CAP_WORD_DEPTH    8

`define CAP_COUNT_W       16  // max_samples range
`define CAP_DOWNSAMPLE_W  13  // skipped samples between captures

// 16 x 12 bits = 3 x 64 bits, smallest sample count that fills whole words
`define CAP_GROUP_SAMPLES 16

`endif

/* hw/capture_pkg.sv */
`default_nettype none

`include "capture_consts.svh"

package capture_pkg;

    typedef logic [`CAP_SAMPLE_W-1:0]     sample_t;
    typedef logic [`CAP_WORD_W-1:0]       word_t;
    typedef logic [`CAP_COUNT_W-1:0]      count_t;
    typedef logic [`CAP_DOWNSAMPLE_W-1:0] downsample_t;

    // capture sequence, DONE lasts one cycle
    typedef enum logic [2:0] {
        IDLE,
        ARMED,
        TRIGGERED,
        FLUSH,
        DONE
    } capture_state_t;

endpackage

`default_nettype wire

/* hw/sample_fifo_if.sv */
`default_nettype none

// push side, pop side and status of one synchronous fifo
interface sample_fifo_if #(
    parameter type payload_t = logic
);
    logic     push;
    payload_t push_data;
    logic     pop;
    payload_t pop_data;   // head item, valid while empty is low
    logic     empty;
    logic     full;
    logic     overflow;   // push seen while full, one cycle

    modport writer (output push, output push_data, input full);

    modport reader (output pop, input pop_data, input empty);

    modport fifo (
        input  push,
        input  push_data,
        input  pop,
        output pop_data,
        output empty,
        output full,
        output overflow
    );

endinterface

`default_nettype wire

/* hw/sample_fifo.sv */
`default_nettype none

module sample_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16
) (
    input  logic        adc_sampleclk,
    input  logic        reset,
    sample_fifo_if.fifo port
);

    localparam int AW = $clog2(DEPTH);

    payload_t    mem [DEPTH];
    logic [AW:0] wr_ptr;   // extra msb tells full from empty
    logic [AW:0] rd_ptr;
    logic        wr_en;
    logic        rd_en;

    assign port.empty    = (wr_ptr == rd_ptr);
    assign port.full     = (wr_ptr[AW] != rd_ptr[AW]) &&
                           (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign port.overflow = port.push && port.full;   // dropped push
    assign port.pop_data = mem[rd_ptr[AW-1:0]];

    assign wr_en = port.push && !port.full;
    assign rd_en = port.pop && !port.empty;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (wr_en)
            mem[wr_ptr[AW-1:0]] <= port.push_data;
    end

endmodule

`default_nettype wire

/* hw/sample_window_counter.sv */
`default_nettype none

module sample_window_counter (
    input  logic                     adc_sampleclk,
    input  logic                     reset,
    input  logic                     count_clear,
    input  logic                     count_en,
    input  capture_pkg::downsample_t downsample_i,
    input  capture_pkg::count_t      max_samples_i,
    output logic                     sample_tick,
    output logic                     window_done
);

    capture_pkg::downsample_t skip_cnt;    // position inside one downsample period
    capture_pkg::count_t      taken_cnt;   // samples captured so far
    capture_pkg::count_t      last_idx;

    // skip_cnt is zero on the trigger edge, so sample 0 lines up with the trigger
    assign sample_tick = count_en && (skip_cnt == '0);
    assign last_idx    = max_samples_i - 1'b1;
    assign window_done = sample_tick && (taken_cnt == last_idx);

    always_ff @(posedge adc_sampleclk) begin
        if (reset || count_clear) begin
            skip_cnt  <= '0;
            taken_cnt <= '0;
        end
        else if (count_en) begin
            if (skip_cnt == downsample_i)
                skip_cnt <= '0;
            else
                skip_cnt <= skip_cnt + 1'b1;

            if (sample_tick)
                taken_cnt <= taken_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/capture_fsm.sv */
`default_nettype none

module capture_fsm (
    input  logic                        adc_sampleclk,
    input  logic                        reset,
    input  logic                        arm_i,
    input  logic                        trigger_i,
    input  logic                        window_done,
    input  logic                        sample_empty,
    input  logic                        group_complete,
    input  logic                        sample_overflow,
    input  logic                        clip_seen,
    output logic                        count_clear,
    output logic                        count_en,
    output logic                        filler_en,
    output logic                        armed_o,
    output logic                        capture_done_o,
    output logic                        fifo_overflow_o,
    output logic                        clip_error_o,
    output capture_pkg::capture_state_t state_o
);

    capture_pkg::capture_state_t state;
    capture_pkg::capture_state_t state_next;
    logic                        arm_r;
    logic                        arm_go;    // arm rising edge accepted in IDLE
    logic                        trig_go;

    assign arm_go  = arm_i && !arm_r && (state == capture_pkg::IDLE);
    assign trig_go = trigger_i && (state == capture_pkg::ARMED);

    always_comb begin
        state_next = state;
        case (state)
            capture_pkg::IDLE: begin
                if (arm_go)
                    state_next = capture_pkg::ARMED;
            end
            capture_pkg::ARMED: begin
                // a one-sample window ends on the trigger edge itself
                if (trig_go)
                    state_next = window_done ? capture_pkg::FLUSH : capture_pkg::TRIGGERED;
            end
            capture_pkg::TRIGGERED: begin
                if (window_done)
                    state_next = capture_pkg::FLUSH;
            end
            capture_pkg::FLUSH: begin
                // drained and packer back on a group boundary
                if (sample_empty && group_complete)
                    state_next = capture_pkg::DONE;
            end
            default: state_next = capture_pkg::IDLE;
        endcase
    end

    assign count_clear = (state == capture_pkg::IDLE);
    assign count_en    = trig_go || (state == capture_pkg::TRIGGERED);
    assign filler_en   = (state == capture_pkg::FLUSH) && !group_complete;
    assign state_o     = state;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state           <= capture_pkg::IDLE;
            arm_r           <= 1'b0;
            armed_o         <= 1'b0;
            capture_done_o  <= 1'b0;
            fifo_overflow_o <= 1'b0;
            clip_error_o    <= 1'b0;
        end
        else begin
            state <= state_next;
            arm_r <= arm_i;

            if (arm_go)
                armed_o <= 1'b1;
            else if (state_next == capture_pkg::DONE)
                armed_o <= 1'b0;

            // sticky until the next arm
            if (arm_go)
                capture_done_o <= 1'b0;
            else if (state_next == capture_pkg::DONE)
                capture_done_o <= 1'b1;

            if (arm_go)
                fifo_overflow_o <= 1'b0;
            else if (sample_overflow)
                fifo_overflow_o <= 1'b1;

            if (arm_go)
                clip_error_o <= 1'b0;
            else if (clip_seen)
                clip_error_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/word_packer.sv */
`default_nettype none

`include "capture_consts.svh"

module word_packer (
    input  logic           adc_sampleclk,
    input  logic           reset,
    input  logic           filler_en,
    sample_fifo_if.reader  src,
    sample_fifo_if.writer  dst,
    output logic           group_complete
);

    localparam int GRP_W   = $clog2(`CAP_GROUP_SAMPLES);
    localparam int SHIFT_W = 6 * `CAP_SAMPLE_W;   // longest word needs 6 samples

    logic [SHIFT_W-1:0]  shifter;
    logic [SHIFT_W-1:0]  shifter_next;
    logic [1:0]          word_idx;   // which word of the three-word cycle
    logic [GRP_W-1:0]    grp_cnt;    // samples taken in the current group
    logic                take_sample;
    logic                take_filler;
    logic                advance;
    logic                word_end;
    logic                word_valid;
    capture_pkg::sample_t in_sample;
    capture_pkg::word_t   word_next;
    capture_pkg::word_t   word_q;

    // no pop while the word fifo is full, back-pressure stays in the sample fifo
    assign take_sample = !src.empty && !dst.full;
    assign take_filler = src.empty && filler_en && !dst.full;
    assign advance     = take_sample || take_filler;
    assign src.pop     = take_sample;

    assign in_sample    = take_sample ? src.pop_data : '0;   // filler is zero
    assign shifter_next = {shifter[SHIFT_W-`CAP_SAMPLE_W-1:0], in_sample};

    // words close after samples 6, 11 and 16 of the group
    assign word_end = (grp_cnt == GRP_W'(5)) || (grp_cnt == GRP_W'(10)) ||
                      (grp_cnt == GRP_W'(`CAP_GROUP_SAMPLES - 1));

    assign group_complete = (grp_cnt == '0);

    always_comb begin
        case (word_idx)
            2'd0:    word_next = shifter_next[71:8];   // 5 samples plus top 4 bits
            2'd1:    word_next = shifter_next[67:4];   // 8 leftover bits first
            default: word_next = shifter_next[63:0];   // 4 leftover bits first
        endcase
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            word_idx   <= 2'd0;
            grp_cnt    <= '0;
            word_valid <= 1'b0;
        end
        else begin
            word_valid <= advance && word_end;
            if (advance) begin
                if (grp_cnt == GRP_W'(`CAP_GROUP_SAMPLES - 1))
                    grp_cnt <= '0;
                else
                    grp_cnt <= grp_cnt + 1'b1;

                if (word_end)
                    word_idx <= (word_idx == 2'd2) ? 2'd0 : word_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (advance)
            shifter <= shifter_next;
        if (advance && word_end)
            word_q <= word_next;
    end

    assign dst.push      = word_valid;   // one edge after the completing sample
    assign dst.push_data = word_q;

endmodule

`default_nettype wire

/* hw/capture_top.sv */
`default_nettype none

`include "capture_consts.svh"

module capture_top (
    input  logic                        adc_sampleclk,
    input  logic                        reset,
    input  capture_pkg::sample_t        adc_data_i,
    input  logic                        arm_i,
    input  logic                        trigger_i,
    input  capture_pkg::count_t         max_samples_i,
    input  capture_pkg::downsample_t    downsample_i,
    input  logic                        word_rd_i,
    output capture_pkg::word_t          word_o,
    output logic                        word_empty_o,
    output logic                        armed_o,
    output logic                        capture_done_o,
    output logic                        fifo_overflow_o,
    output logic                        clip_error_o,
    output capture_pkg::capture_state_t state_o
);

    logic count_clear;
    logic count_en;
    logic sample_tick;
    logic window_done;
    logic filler_en;
    logic group_complete;
    logic clip_seen;

    sample_fifo_if #(.payload_t(capture_pkg::sample_t)) smp_if ();
    sample_fifo_if #(.payload_t(capture_pkg::word_t))   wrd_if ();

    // adc side of the sample fifo
    assign smp_if.push      = sample_tick;
    assign smp_if.push_data = adc_data_i;

    // rail values on a captured sample mean the input is clipping
    assign clip_seen = sample_tick && ((adc_data_i == '1) || (adc_data_i == '0));

    // external read side of the word fifo
    assign wrd_if.pop   = word_rd_i && !wrd_if.empty;
    assign word_o       = wrd_if.pop_data;
    assign word_empty_o = wrd_if.empty;

    capture_fsm u_fsm (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .arm_i           (arm_i),
        .trigger_i       (trigger_i),
        .window_done     (window_done),
        .sample_empty    (smp_if.empty),
        .group_complete  (group_complete),
        .sample_overflow (smp_if.overflow),
        .clip_seen       (clip_seen),
        .count_clear     (count_clear),
        .count_en        (count_en),
        .filler_en       (filler_en),
        .armed_o         (armed_o),
        .capture_done_o  (capture_done_o),
        .fifo_overflow_o (fifo_overflow_o),
        .clip_error_o    (clip_error_o),
        .state_o         (state_o)
    );

    sample_window_counter u_window (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .count_clear   (count_clear),
        .count_en      (count_en),
        .downsample_i  (downsample_i),
        .max_samples_i (max_samples_i),
        .sample_tick   (sample_tick),
        .window_done   (window_done)
    );

    sample_fifo #(
        .payload_t (capture_pkg::sample_t),
        .DEPTH     (`CAP_SAMPLE_DEPTH)
    ) u_sample_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .port          (smp_if)
    );

    word_packer u_packer (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .filler_en      (filler_en),
        .src            (smp_if),
        .dst            (wrd_if),
        .group_complete (group_complete)
    );

    sample_fifo #(
        .payload_t (capture_pkg::word_t),
        .DEPTH     (`CAP_WORD_DEPTH)
    ) u_word_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .port          (wrd_if)
    );

endmodule

`default_nettype wire

/* testbench/capture_props.sv */
`default_nettype none

module capture_props (
    input logic                        adc_sampleclk,
    input logic                        reset,
    input logic                        pop,
    input logic                        empty,
    input capture_pkg::capture_state_t state_o,
    input logic                        capture_done_o,
    input logic                        arm_i
);

    int unsigned assert_fails;   // summed into the testbench verdict
    logic        armed_once;

    initial assert_fails = 0;

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            armed_once <= 1'b0;
        else if (arm_i)
            armed_once <= 1'b1;
    end

    no_pop_on_empty: assert property (@(posedge adc_sampleclk) disable iff (reset)
        empty |-> !pop)
    else begin
        assert_fails++;
        $error("pop issued while the fifo is empty");
    end

    no_done_before_arm: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (!armed_once && state_o == capture_pkg::IDLE) |-> !capture_done_o)
    else begin
        assert_fails++;
        $error("capture_done_o high in IDLE before any arm");
    end

    legal_state: assert property (@(posedge adc_sampleclk) disable iff (reset)
        state_o inside {capture_pkg::IDLE, capture_pkg::ARMED, capture_pkg::TRIGGERED,
                        capture_pkg::FLUSH, capture_pkg::DONE})
    else begin
        assert_fails++;
        $error("state_o holds an encoding outside the state enum");
    end

endmodule

// fsm side, the fifo rule is tied off
bind capture_fsm capture_props fsm_props0 (
    .adc_sampleclk  (adc_sampleclk),
    .reset          (reset),
    .pop            (1'b0),
    .empty          (1'b1),
    .state_o        (state_o),
    .capture_done_o (capture_done_o),
    .arm_i          (arm_i)
);

// both fifo instances, fsm rules tied off
bind sample_fifo capture_props fifo_props0 (
    .adc_sampleclk  (adc_sampleclk),
    .reset          (reset),
    .pop            (port.pop),
    .empty          (port.empty),
    .state_o        (capture_pkg::IDLE),
    .capture_done_o (1'b0),
    .arm_i          (1'b0)
);

`default_nettype wire

/* testbench/capture_tb.sv */
`default_nettype none

`include "capture_consts.svh"

module capture_tb;

    localparam int N_ROWS = 6;

    typedef struct packed {
        logic [15:0] max_samples;
        logic [12:0] downsample;
        logic [7:0]  trig_delay;   // zero picks a random delay
        logic        read_en;      // word_rd_i level while capturing
        logic        exp_ovf;
        logic        exp_clip;
    } row_t;

    logic                        adc_sampleclk;
    logic                        reset;
    capture_pkg::sample_t        adc_data_i = '0;
    logic                        arm_i;
    logic                        trigger_i;
    capture_pkg::count_t         max_samples_i;
    capture_pkg::downsample_t    downsample_i;
    logic                        word_rd_i;
    capture_pkg::word_t          word_o;
    logic                        word_empty_o;
    logic                        armed_o;
    logic                        capture_done_o;
    logic                        fifo_overflow_o;
    logic                        clip_error_o;
    capture_pkg::capture_state_t state_o;

    row_t        rows [N_ROWS];
    int unsigned edge_cnt = 0;
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit;
    logic        force_clip;     // pins the adc input at full scale
    logic [31:0] rng_state;
    int          mismatch_cnt;
    int          other_err_cnt;
    int          cur_first;      // ramp value on the trigger edge
    int          cur_max;
    int          cur_ds;
    logic        cur_clip;

    capture_top dut0 (.*);

    always #5 adc_sampleclk = ~adc_sampleclk;

    // ramp source, one step per edge
    always @(posedge adc_sampleclk) begin
        edge_cnt   <= edge_cnt + 1;
        adc_data_i <= force_clip ? 12'hFFF : capture_pkg::sample_t'(edge_cnt + 1);
    end

    always @(posedge adc_sampleclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("ERROR: timeout after %0d cycles, capture never completed", cycle_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic capture_pkg::sample_t expected_sample(input int k);
        if (k >= cur_max)
            return '0;   // filler closing the group
        else if (cur_clip)
            return '1;
        else
            return capture_pkg::sample_t'(cur_first + k * (cur_ds + 1));
    endfunction

    // sample 0 sits in the msbs of word 0, samples follow back to back
    function automatic capture_pkg::word_t expected_word(input int w);
        capture_pkg::word_t   word;
        capture_pkg::sample_t smp;
        int                   pos;
        int                   b;
        for (b = 0; b < `CAP_WORD_W; b++) begin
            pos = w * `CAP_WORD_W + b;
            smp = expected_sample(pos / `CAP_SAMPLE_W);
            word[`CAP_WORD_W - 1 - b] = smp[`CAP_SAMPLE_W - 1 - (pos % `CAP_SAMPLE_W)];
        end
        return word;
    endfunction

    task automatic check_word(input int idx, input capture_pkg::word_t got,
                              input capture_pkg::word_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH word_o (word %0d): got 0x%h, expected 0x%h", idx, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_state(input capture_pkg::capture_state_t got,
                               input capture_pkg::capture_state_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH state_o: got 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic run_row(input int r);
        capture_pkg::word_t got_words [$];
        int                 delay;
        int                 n_exp;
        int                 wait_cnt;
        int                 window;
        int                 w;
        logic               done_seen;

        cur_max  = int'(rows[r].max_samples);
        cur_ds   = int'(rows[r].downsample);
        cur_clip = rows[r].exp_clip;
        window   = cur_max * (cur_ds + 1);

        repeat (2) @(posedge adc_sampleclk);
        arm_i         <= 1'b1;
        max_samples_i <= capture_pkg::count_t'(cur_max);
        downsample_i  <= capture_pkg::downsample_t'(cur_ds);
        word_rd_i     <= rows[r].read_en;
        force_clip    <= rows[r].exp_clip;
        @(posedge adc_sampleclk);
        arm_i <= 1'b0;
        @(negedge adc_sampleclk);
        check_flag("armed_o", armed_o, 1'b1);   // arm clears the sticky flags
        check_flag("capture_done_o", capture_done_o, 1'b0);
        check_flag("fifo_overflow_o", fifo_overflow_o, 1'b0);
        check_flag("clip_error_o", clip_error_o, 1'b0);

        delay = int'(rows[r].trig_delay);
        if (delay == 0) begin
            rng_state = xorshift32(rng_state);
            delay     = 2 + int'(rng_state % 8);
        end
        repeat (delay) @(posedge adc_sampleclk);
        trigger_i <= 1'b1;
        @(negedge adc_sampleclk);
        cur_first = int'(adc_data_i);   // sampled by the dut on the next edge

        wait_cnt  = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(posedge adc_sampleclk);
            trigger_i <= 1'b0;
            if (wait_cnt == window + 20)
                word_rd_i <= 1'b1;   // release back-pressure after the window
            @(negedge adc_sampleclk);
            wait_cnt++;
            if (word_rd_i && !word_empty_o)
                got_words.push_back(word_o);   // popped on the coming edge
            if (capture_done_o) begin
                done_seen = 1'b1;
                check_state(state_o, capture_pkg::DONE);
            end
        end
        check_flag("fifo_overflow_o", fifo_overflow_o, rows[r].exp_ovf);
        check_flag("clip_error_o", clip_error_o, rows[r].exp_clip);

        while (!word_empty_o) begin
            @(posedge adc_sampleclk);
            @(negedge adc_sampleclk);
            if (word_rd_i && !word_empty_o)
                got_words.push_back(word_o);
        end
        @(posedge adc_sampleclk);
        word_rd_i  <= 1'b0;
        force_clip <= 1'b0;

        // dropped samples make the word contents of an overflow run unknown
        n_exp = (cur_max + `CAP_GROUP_SAMPLES - 1) / `CAP_GROUP_SAMPLES *
                (`CAP_GROUP_SAMPLES * `CAP_SAMPLE_W / `CAP_WORD_W);
        if (!rows[r].exp_ovf) begin
            if (got_words.size() != n_exp) begin
                other_err_cnt++;
                $display("ERROR: row %0d read %0d words where %0d were expected",
                         r, got_words.size(), n_exp);
            end
            for (w = 0; w < got_words.size() && w < n_exp; w++)
                check_word(w, got_words[w], expected_word(w));
        end
    endtask

    initial begin
        int          r;
        int unsigned props_fails;

        adc_sampleclk = 1'b0;
        reset         = 1'b1;
        arm_i         = 1'b0;
        trigger_i     = 1'b0;
        max_samples_i = '0;
        downsample_i  = '0;
        word_rd_i     = 1'b0;
        force_clip    = 1'b0;
        rng_state     = 32'h6192;
        mismatch_cnt  = 0;
        other_err_cnt = 0;

        rows[0] = '{16'd32, 13'd0, 8'd3, 1'b1, 1'b0, 1'b0};   // plain ramp
        rows[1] = '{16'd32, 13'd3, 8'd0, 1'b1, 1'b0, 1'b0};   // every fourth edge
        rows[2] = '{16'd20, 13'd0, 8'd0, 1'b1, 1'b0, 1'b0};   // 12 filler slots
        rows[3] = '{16'd64, 13'd0, 8'd5, 1'b0, 1'b1, 1'b0};   // no reads, overflow
        rows[4] = '{16'd32, 13'd1, 8'd0, 1'b1, 1'b0, 1'b1};   // full scale input
        rows[5] = '{16'd16, 13'd1, 8'd4, 1'b1, 1'b0, 1'b0};

        cycle_limit = 0;
        for (r = 0; r < N_ROWS; r++)
            cycle_limit += int'(rows[r].max_samples) * (int'(rows[r].downsample) + 1) + 200;

        repeat (8) @(posedge adc_sampleclk);
        reset <= 1'b0;
        @(negedge adc_sampleclk);
        check_flag("armed_o", armed_o, 1'b0);
        check_flag("capture_done_o", capture_done_o, 1'b0);
        check_flag("fifo_overflow_o", fifo_overflow_o, 1'b0);
        check_flag("clip_error_o", clip_error_o, 1'b0);
        check_flag("word_empty_o", word_empty_o, 1'b1);
        check_state(state_o, capture_pkg::IDLE);

        for (r = 0; r < N_ROWS; r++)
            run_row(r);

        props_fails = dut0.u_fsm.fsm_props0.assert_fails +
                      dut0.u_sample_fifo.fifo_props0.assert_fails +
                      dut0.u_word_fifo.fifo_props0.assert_fails;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatch_cnt, other_err_cnt, props_fails);
        if (mismatch_cnt == 0 && other_err_cnt == 0 && props_fails == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hw/capture_pkg.sv
hw/sample_fifo_if.sv
hw/sample_fifo.sv
hw/sample_window_counter.sv
hw/capture_fsm.sv
hw/word_packer.sv
hw/capture_top.sv
testbench/capture_props.sv
testbench/capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the capture testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module capture_tb -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vcapture_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
exit 1
